/* design/mpmem_defines.svh */
`ifndef MPMEM_DEFINES_SVH
`define MPMEM_DEFINES_SVH

// Word and address sizes
`define MPMEM_DW      16
`define MPMEM_AW      8    // Bank in the top bits, row below

`define MPMEM_NWR     4    // Write ports
`define MPMEM_NRD     2    // Read ports
`define MPMEM_NBANK   4
`define MPMEM_NROW    64

`define MPMEM_FDEPTH  16   // Shared write FIFO
`define MPMEM_FCW     5    // Holds 0 to FDEPTH

`endif

/* design/mpmem_pkg.sv */
`include "mpmem_defines.svh"

package mpmem_pkg;

  // One queued write
  typedef struct packed {
    logic [`MPMEM_AW-1:0] addr;
    logic [`MPMEM_DW-1:0] data;
  } wr_entry_t;

  // Read request from one port
  typedef struct packed {
    logic [`MPMEM_AW-1:0] addr;
  } rd_req_t;

  // Registered read result
  typedef struct packed {
    logic                 valid;
    logic [`MPMEM_DW-1:0] data;
  } rd_rsp_t;

endpackage

/* design/mpmem_ctrl.sv */
`timescale 1ns/1ps
`include "mpmem_defines.svh"

module mpmem_ctrl (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [`MPMEM_NWR-1:0]               write,
  input  logic [`MPMEM_FCW-1:0]               bp_thr,
  input  logic [1:0][`MPMEM_AW-1:0]           head_addr,
  input  logic [`MPMEM_FCW-1:0]               fifo_count,
  input  logic [`MPMEM_NRD-1:0]               read,
  input  mpmem_pkg::rd_req_t [`MPMEM_NRD-1:0] rd_req,
  output logic                                ready,
  output logic                                wr_bp,
  output logic [`MPMEM_NWR-1:0]               push_mask,
  output logic [1:0]                          pop_count,
  output logic [1:0]                          drain_en,
  output logic                                clr_en,
  output logic [$clog2(`MPMEM_NROW)-1:0]      clr_row
);

  localparam int RW  = $clog2(`MPMEM_NROW);
  localparam int BW  = $clog2(`MPMEM_NBANK);
  localparam int PCW = $clog2(`MPMEM_NWR + 1);
  localparam int CW  = `MPMEM_FCW + 1;  // Room to see an overflow

  logic [PCW-1:0] npush;
  logic [CW-1:0]  count_nxt;
  logic [BW-1:0]  head_bank [2];

  // Init sweep, one row per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ready   <= 1'b0;
      clr_row <= '0;
    end else if (!ready) begin
      clr_row <= clr_row + 1'b1;
      if (clr_row == RW'(`MPMEM_NROW - 1)) begin
        ready <= 1'b1;
      end
    end
  end

  assign clr_en    = ~ready;
  assign push_mask = write & {`MPMEM_NWR{ready}};  // Nothing enters during init

  always_comb begin
    npush = '0;
    for (int i = 0; i < `MPMEM_NWR; i++) begin
      npush = npush + PCW'(push_mask[i]);
    end
  end

  // Drain one, or two when the heads sit in different banks
  always_comb begin
    head_bank[0] = head_addr[0][`MPMEM_AW-1 -: BW];
    head_bank[1] = head_addr[1][`MPMEM_AW-1 -: BW];
    if (fifo_count == '0) begin
      pop_count = 2'd0;
    end else if (fifo_count > `MPMEM_FCW'(1) && head_bank[0] != head_bank[1]) begin
      pop_count = 2'd2;
    end else begin
      pop_count = 2'd1;
    end
  end

  assign drain_en  = {pop_count == 2'd2, pop_count != 2'd0};
  assign count_nxt = CW'(fifo_count) + CW'(npush) - CW'(pop_count);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_bp <= 1'b0;
    end else begin
      wr_bp <= count_nxt > CW'(bp_thr);  // Advisory only
    end
  end

  a_fifo_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) count_nxt <= CW'(`MPMEM_FDEPTH))
    else $error("%m: write FIFO overflow, next count %0d", count_nxt);

  // Each bank has a single read port
  for (genvar m = 0; m < `MPMEM_NRD; m++) begin : g_rd_a
    for (genvar n = 0; n < m; n++) begin : g_rd_b
      a_rd_bank_conflict: assert property (
        @(posedge clk) disable iff (!rst_n)
        (read[m] && read[n]) |->
          (rd_req[m].addr[`MPMEM_AW-1 -: BW] != rd_req[n].addr[`MPMEM_AW-1 -: BW]))
        else $error("%m: reads %0d and %0d hit bank %0d", m, n,
                    rd_req[m].addr[`MPMEM_AW-1 -: BW]);
    end
  end

endmodule

/* design/wr_fifo.sv */
`timescale 1ns/1ps
`include "mpmem_defines.svh"

module wr_fifo (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [`MPMEM_NWR-1:0]                 push_mask,
  input  mpmem_pkg::wr_entry_t [`MPMEM_NWR-1:0] push_data,
  input  logic [1:0]                            pop_count,
  output mpmem_pkg::wr_entry_t [1:0]            head_data,
  output logic [`MPMEM_FCW-1:0]                 count
);

  localparam int PW  = $clog2(`MPMEM_FDEPTH);
  localparam int PCW = $clog2(`MPMEM_NWR + 1);

  mpmem_pkg::wr_entry_t mem [`MPMEM_FDEPTH];

  logic [PW-1:0]  wr_ptr;
  logic [PW-1:0]  rd_ptr;
  logic [PW-1:0]  slot [`MPMEM_NWR];
  logic [PCW-1:0] npush;

  // Pack active lanes into consecutive slots, port order kept
  always_comb begin
    npush = '0;
    for (int i = 0; i < `MPMEM_NWR; i++) begin
      slot[i] = wr_ptr + PW'(npush);
      npush   = npush + PCW'(push_mask[i]);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `MPMEM_NWR; i++) begin
      if (push_mask[i]) begin
        mem[slot[i]] <= push_data[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + PW'(npush);
      rd_ptr <= rd_ptr + PW'(pop_count);
      count  <= count + `MPMEM_FCW'(npush) - `MPMEM_FCW'(pop_count);
    end
  end

  // Second head is only meaningful when count > 1
  assign head_data[0] = mem[rd_ptr];
  assign head_data[1] = mem[rd_ptr + PW'(1)];

  a_pop_underflow: assert property (
    @(posedge clk) disable iff (!rst_n) `MPMEM_FCW'(pop_count) <= count)
    else $error("%m: pop of %0d with only %0d queued", pop_count, count);

endmodule

/* design/bank_array.sv */
`timescale 1ns/1ps
`include "mpmem_defines.svh"

module bank_array (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic [1:0]                          drain_en,
  input  mpmem_pkg::wr_entry_t [1:0]          drain_data,
  input  logic                                clr_en,
  input  logic [$clog2(`MPMEM_NROW)-1:0]      clr_row,
  input  logic [`MPMEM_NRD-1:0]               read,
  input  mpmem_pkg::rd_req_t [`MPMEM_NRD-1:0] rd_req,
  output mpmem_pkg::rd_rsp_t [`MPMEM_NRD-1:0] rd_rsp
);

  localparam int RW = $clog2(`MPMEM_NROW);
  localparam int BW = $clog2(`MPMEM_NBANK);

  logic [`MPMEM_DW-1:0] mem [`MPMEM_NBANK][`MPMEM_NROW];

  logic [BW-1:0]        dbank [2];
  logic [RW-1:0]        drow  [2];
  logic [`MPMEM_NRD-1:0] rsp_vld;
  logic [`MPMEM_DW-1:0] rsp_data [`MPMEM_NRD];

  always_comb begin
    for (int l = 0; l < 2; l++) begin
      dbank[l] = drain_data[l].addr[`MPMEM_AW-1 -: BW];
      drow[l]  = drain_data[l].addr[RW-1:0];
    end
  end

  // One write per bank per cycle, clear wins during init
  always_ff @(posedge clk) begin
    for (int b = 0; b < `MPMEM_NBANK; b++) begin
      if (clr_en) begin
        mem[b][clr_row] <= '0;
      end else if (drain_en[0] && dbank[0] == BW'(b)) begin
        mem[b][drow[0]] <= drain_data[0].data;
      end else if (drain_en[1] && dbank[1] == BW'(b)) begin
        mem[b][drow[1]] <= drain_data[1].data;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld <= '0;
    end else begin
      rsp_vld <= read;
    end
  end

  // Old data on a same-cycle drain to the read address
  always_ff @(posedge clk) begin
    for (int j = 0; j < `MPMEM_NRD; j++) begin
      if (read[j]) begin
        rsp_data[j] <= mem[rd_req[j].addr[`MPMEM_AW-1 -: BW]][rd_req[j].addr[RW-1:0]];
      end
    end
  end

  always_comb begin
    for (int j = 0; j < `MPMEM_NRD; j++) begin
      rd_rsp[j].valid = rsp_vld[j];
      rd_rsp[j].data  = rsp_data[j];
    end
  end

  a_drain_bank_conflict: assert property (
    @(posedge clk) disable iff (!rst_n) (&drain_en) |-> (dbank[0] != dbank[1]))
    else $error("%m: both drain lanes target bank %0d", dbank[0]);

endmodule

/* design/mpmem_top.sv */
`timescale 1ns/1ps
`include "mpmem_defines.svh"

module mpmem_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  output logic                                  ready,
  input  logic [`MPMEM_NWR-1:0]                 write,
  input  mpmem_pkg::wr_entry_t [`MPMEM_NWR-1:0] wr_data,
  output logic                                  wr_bp,
  input  logic [`MPMEM_FCW-1:0]                 bp_thr,
  input  logic [`MPMEM_NRD-1:0]                 read,
  input  mpmem_pkg::rd_req_t [`MPMEM_NRD-1:0]   rd_req,
  output mpmem_pkg::rd_rsp_t [`MPMEM_NRD-1:0]   rd_rsp
);

  logic [`MPMEM_NWR-1:0]              push_mask;
  logic [1:0]                         pop_count;
  logic [1:0]                         drain_en;
  logic                               clr_en;
  logic [$clog2(`MPMEM_NROW)-1:0]     clr_row;
  logic [`MPMEM_FCW-1:0]              fifo_count;
  mpmem_pkg::wr_entry_t [1:0]         head_data;

  mpmem_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .write      (write),
    .bp_thr     (bp_thr),
    .head_addr  ({head_data[1].addr, head_data[0].addr}),
    .fifo_count (fifo_count),
    .read       (read),
    .rd_req     (rd_req),
    .ready      (ready),
    .wr_bp      (wr_bp),
    .push_mask  (push_mask),
    .pop_count  (pop_count),
    .drain_en   (drain_en),
    .clr_en     (clr_en),
    .clr_row    (clr_row)
  );

  wr_fifo u_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_mask  (push_mask),
    .push_data  (wr_data),
    .pop_count  (pop_count),
    .head_data  (head_data),
    .count      (fifo_count)
  );

  bank_array u_banks (
    .clk        (clk),
    .rst_n      (rst_n),
    .drain_en   (drain_en),
    .drain_data (head_data),  // FIFO heads feed the drain lanes
    .clr_en     (clr_en),
    .clr_row    (clr_row),
    .read       (read),
    .rd_req     (rd_req),
    .rd_rsp     (rd_rsp)
  );

endmodule

/* bench/mpmem_tb.sv */
`timescale 1ns/1ps
`include "mpmem_defines.svh"

module mpmem_tb;

  logic                                  clk;
  logic                                  rst_n;
  logic                                  ready;
  logic [`MPMEM_NWR-1:0]                 write;
  mpmem_pkg::wr_entry_t [`MPMEM_NWR-1:0] wr_data;
  logic                                  wr_bp;
  logic [`MPMEM_FCW-1:0]                 bp_thr;
  logic [`MPMEM_NRD-1:0]                 read;
  mpmem_pkg::rd_req_t [`MPMEM_NRD-1:0]   rd_req;
  mpmem_pkg::rd_rsp_t [`MPMEM_NRD-1:0]   rd_rsp;

  logic [`MPMEM_DW-1:0] ref_mem [2**`MPMEM_AW];
  logic [`MPMEM_DW-1:0] exp_q [`MPMEM_NRD];
  logic [15:0]          lfsr;
  logic [`MPMEM_AW-1:0] written [$];
  int                   errors;
  int                   n_pass;
  int                   n_fail;

  mpmem_top u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .ready   (ready),
    .write   (write),
    .wr_data (wr_data),
    .wr_bp   (wr_bp),
    .bp_thr  (bp_thr),
    .read    (read),
    .rd_req  (rd_req),
    .rd_rsp  (rd_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < `MPMEM_NRD; j++) begin
      exp_q[j] <= ref_mem[rd_req[j].addr];  // Expected word at the read edge
    end
  end

  for (genvar j = 0; j < `MPMEM_NRD; j++) begin : g_chk
    a_rsp_valid: assert property (
      @(posedge clk) disable iff (!rst_n) read[j] |=> rd_rsp[j].valid)
      else begin
        errors++;
        $display("FAIL %0t rd_rsp[%0d].valid got 0 expected 1", $time, j);
      end
    a_rsp_spurious: assert property (
      @(posedge clk) disable iff (!rst_n) !read[j] |=> !rd_rsp[j].valid)
      else begin
        errors++;
        $display("FAIL %0t rd_rsp[%0d].valid got 1 expected 0", $time, j);
      end
    a_rsp_data: assert property (
      @(posedge clk) disable iff (!rst_n) read[j] |=> (rd_rsp[j].data == exp_q[j]))
      else begin
        errors++;
        $display("FAIL %0t rd_rsp[%0d].data got %h expected %h", $time, j,
                 $sampled(rd_rsp[j].data), $sampled(exp_q[j]));
      end
  end

  // Galois LFSR, one step per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    logic        b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b    = lfsr[0];
      lfsr = (lfsr >> 1) ^ (b ? 16'hB400 : 16'h0000);
      r    = {r[14:0], b};
    end
    return r;
  endfunction

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!ready && n < 200) begin
      step();
      n++;
    end
    if (!ready) begin
      errors++;
      $display("ERROR %0t: ready did not rise within 200 cycles", $time);
    end
  endtask

  // Zero threshold makes wr_bp mean FIFO not empty
  task automatic drain_wait();
    int n;
    n = 0;
    bp_thr = '0;
    step();
    while (wr_bp && n < 100) begin
      step();
      n++;
    end
    if (wr_bp) begin
      errors++;
      $display("ERROR %0t: write FIFO did not empty within 100 cycles", $time);
    end
  endtask

  task automatic put_write(input int port, input logic [7:0] a, input logic [15:0] d);
    write[port]        = 1'b1;
    wr_data[port].addr = a;
    wr_data[port].data = d;
  endtask

  task automatic commit_writes();
    for (int i = 0; i < `MPMEM_NWR; i++) begin
      if (write[i]) begin
        ref_mem[wr_data[i].addr] = wr_data[i].data;  // Higher port lands later
        written.push_back(wr_data[i].addr);
      end
    end
    step();
    write = '0;
  endtask

  task automatic read_pair(input logic [7:0] a0, input logic [7:0] a1);
    read           = '1;
    rd_req[0].addr = a0;
    rd_req[1].addr = a1;
    step();
    read = '0;
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before) begin
      n_pass++;
      $display("test %s: ok", name);
    end else begin
      n_fail++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  initial begin
    int                   e0;
    int                   n;
    logic [`MPMEM_AW-1:0] a;
    logic [`MPMEM_DW-1:0] d;
    logic [1:0]           bank;
    logic [5:0]           row;
    rst_n   = 1'b0;
    write   = '0;
    wr_data = '0;
    bp_thr  = '0;
    read    = '0;
    rd_req  = '0;
    errors  = 0;
    n_pass  = 0;
    n_fail  = 0;
    lfsr    = 16'd12362;
    for (int i = 0; i < 2**`MPMEM_AW; i++) begin
      ref_mem[i] = '0;
    end

    e0 = errors;
    repeat (16) @(posedge clk);
    expect_bit("ready", ready, 1'b0);
    expect_bit("wr_bp", wr_bp, 1'b0);
    expect_bit("rd_rsp[0].valid", rd_rsp[0].valid, 1'b0);
    expect_bit("rd_rsp[1].valid", rd_rsp[1].valid, 1'b0);
    #1;
    rst_n = 1'b1;
    wait_ready();
    for (int k = 0; k < 6; k++) begin
      a = 8'(rand_bits(8));
      read_pair(a, a ^ 8'h80);  // Other bank on port 1
    end
    step();
    finish_test("reset and clear", e0);

    e0 = errors;
    a  = 8'(rand_bits(8));
    d  = 16'(rand_bits(16));
    put_write(int'(rand_bits(2)), a, d);
    commit_writes();
    drain_wait();
    read_pair(a, a ^ 8'h80);
    step();
    finish_test("single write", e0);

    e0   = errors;
    bank = 2'(rand_bits(2));
    row  = 6'(rand_bits(6));
    for (int i = 0; i < `MPMEM_NWR; i++) begin
      put_write(i, {bank, 6'(row + 6'(i))}, 16'(rand_bits(16)));
    end
    commit_writes();
    drain_wait();
    for (int i = 0; i < `MPMEM_NWR; i++) begin
      a = {bank, 6'(row + 6'(i))};
      read_pair(a, a ^ 8'h80);
    end
    step();
    finish_test("same bank burst", e0);

    e0 = errors;
    a  = 8'(rand_bits(8));
    d  = 16'(rand_bits(16));
    put_write(0, a, d);
    put_write(3, a, ~d);
    commit_writes();
    drain_wait();
    read_pair(a, a ^ 8'h80);
    step();
    finish_test("same address collision", e0);

    e0 = errors;
    written.delete();
    bp_thr = 5'd6;
    n = 0;
    while (!wr_bp && n < 20) begin
      for (int i = 0; i < `MPMEM_NWR; i++) begin
        put_write(i, 8'(rand_bits(8)), 16'(rand_bits(16)));
      end
      commit_writes();
      n++;
    end
    if (!wr_bp) begin
      errors++;
      $display("ERROR %0t: wr_bp did not rise after 20 write bursts", $time);
    end
    n = 0;
    while (wr_bp && n < 50) begin
      step();
      n++;
    end
    if (wr_bp) begin
      errors++;
      $display("ERROR %0t: wr_bp did not fall within 50 cycles", $time);
    end
    drain_wait();
    foreach (written[k]) begin
      read_pair(written[k], written[k] ^ 8'h80);
    end
    step();
    finish_test("back-pressure burst", e0);

    $display("Summary: %0d ok, %0d failing, %0d errors", n_pass, n_fail, errors);
    if (n_fail == 0 && errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+design
design/mpmem_pkg.sv
design/mpmem_ctrl.sv
design/wr_fifo.sv
design/bank_array.sv
design/mpmem_top.sv
bench/mpmem_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module mpmem_tb -f flist.f -o mpmem_sim \
  && ./obj_dir/mpmem_sim > sim.log 2>&1 \
  || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "TESTS PASSED" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }
